/* project.f */
hdl/ciPackage.sv
hdl/ciDecoder.sv
hdl/ciBitOperations.sv
hdl/ciDelayUnit.sv
hdl/ciResultCollector.sv
hdl/ciSubsystem.sv
verification/ciSubsystem_assertions.sv
verification/ciSubsystemTb.sv

/* Bender.yml */
package:
  name: ci_subsystem

sources:
  - files:
      - hdl/ciPackage.sv
      - hdl/ciDecoder.sv
      - hdl/ciBitOperations.sv
      - hdl/ciDelayUnit.sv
      - hdl/ciResultCollector.sv
      - hdl/ciSubsystem.sv
  - target: test
    files:
      - verification/ciSubsystem_assertions.sv
      - verification/ciSubsystemTb.sv

/* verification/ciSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module ciSubsystemTb;

  import ciPackage::*;

  localparam int swapCount        = 200;
  // each loop pass issues a swap and one other instruction, plus two info reads
  localparam int instructionCount = 2 * swapCount + 2;
  localparam int worstCaseCycles  = 2 + 15 * cyclesPerMicrosecond + 4;
  localparam int timeoutCycles    = instructionCount * worstCaseCycles + 100;

  logic                     s_systemClock;
  logic                     s_pllLocked;
  logic                     ciStart;
  logic [ciNumberWidth-1:0] ciN;
  logic [ciDataWidth-1:0]   ciDataA;
  logic [ciDataWidth-1:0]   ciDataB;
  logic                     ciDone;
  logic [ciDataWidth-1:0]   ciResult;

  integer                  seed;
  logic [ciCountWidth-1:0] completedCount;

  ciSubsystem u_dut (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #2 s_systemClock = ~s_systemClock;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [ciDataWidth-1:0] reverseBytes(input logic [ciDataWidth-1:0] value);
    logic [ciDataWidth-1:0] reversed;
    for (int byteIndex = 0; byteIndex < 4; byteIndex++) begin
      reversed[8*byteIndex +: 8] = value[8*(3-byteIndex) +: 8];
    end
    return reversed;
  endfunction

  // B minus A borrows exactly when A is the larger unsigned value
  function automatic logic [ciDataWidth-1:0] unsignedGreater(
    input logic [ciDataWidth-1:0] a,
    input logic [ciDataWidth-1:0] b
  );
    logic [ciDataWidth:0] difference;
    difference = {1'b0, b} - {1'b0, a};
    return {{(ciDataWidth-1){1'b0}}, difference[ciDataWidth]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic stopOnFailure();
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic checkValue(
    input string                  testName,
    input logic [ciDataWidth-1:0] expected,
    input logic [ciDataWidth-1:0] actual
  );
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", testName, expected, actual);
      stopOnFailure();
    end
  endtask

  // starts one instruction and follows it cycle by cycle up to its predicted done
  task automatic runInstruction(
    input string                    testName,
    input logic [ciNumberWidth-1:0] number,
    input logic [ciDataWidth-1:0]   operandA,
    input logic [ciDataWidth-1:0]   operandB,
    input logic [ciDataWidth-1:0]   expectedResult,
    input int                       latency
  );
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= number;
    ciDataA <= operandA;
    ciDataB <= operandB;
    @(posedge s_systemClock);
    ciStart <= 1'b0;
    ciN     <= $random(seed);
    ciDataA <= $random(seed);
    ciDataB <= $random(seed);
    for (int cycle = 1; cycle <= latency; cycle++) begin
      @(negedge s_systemClock);
      if (cycle < latency && ciDone !== 1'b0) begin
        $display("%s: done came %0d cycles after start but was expected after %0d cycles",
                 testName, cycle, latency);
        stopOnFailure();
      end
      if (cycle == latency && ciDone !== 1'b1) begin
        $display("%s: no done pulse %0d cycles after start", testName, latency);
        stopOnFailure();
      end
    end
    checkValue(testName, expectedResult, ciResult);
    completedCount = completedCount + 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction tests
  //////////////////////////////////////////////////////////////////////

  task automatic runSwap();
    logic [ciDataWidth-1:0] a;
    a = $random(seed);
    runInstruction("byte swap", ciSwapByteId, a, $random(seed), reverseBytes(a), 2);
  endtask

  task automatic runCompare(input bit equalPair);
    logic [ciDataWidth-1:0] a;
    logic [ciDataWidth-1:0] b;
    string                  testName;
    a = $random(seed);
    if (equalPair) begin
      b        = a;
      testName = "compare equal";
    end else begin
      b        = $random(seed);
      testName = "compare random";
    end
    runInstruction(testName, ciCompareId, a, b, unsignedGreater(a, b), 2);
  endtask

  task automatic runDelay();
    int microseconds;
    microseconds = $unsigned($random(seed)) % 16;
    runInstruction("microsecond delay", ciDelayId, microseconds, $random(seed), '0,
                   2 + microseconds * cyclesPerMicrosecond);
  endtask

  task automatic runInfo(input string testName);
    runInstruction(testName, ciProcessorInfoId, $random(seed), $random(seed),
                   {processorId, completedCount}, 2);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    int choice;
    seed           = 16;
    completedCount = '0;
    ciStart        = 1'b0;
    ciN            = '0;
    ciDataA        = '0;
    ciDataB        = '0;
    // a short high phase gives the asynchronous reset a clean falling edge
    s_pllLocked    = 1'b1;
    #1;
    s_pllLocked    = 1'b0;
    repeat (2) @(posedge s_systemClock);
    s_pllLocked <= 1'b1;

    // out of reset, done stays low until the first start
    repeat (5) begin
      @(negedge s_systemClock);
      checkValue("done idle after reset", '0, {{(ciDataWidth-1){1'b0}}, ciDone});
    end
    runInfo("first processor info");

    for (int pass = 0; pass < swapCount; pass++) begin
      runSwap();
      choice = $unsigned($random(seed)) % 5;
      case (choice)
        0, 1:    runCompare(1'b0);
        2:       runCompare(1'b1);
        3:       runDelay();
        default: runInfo("interleaved processor info");
      endcase
    end

    runInfo("final processor info");
    $display("Simulation PASSED");
    $finish;
  end

  // the bound checker raises its flag on any failed handshake assertion
  initial begin
    wait (u_dut.u_assertions.assertionFailed === 1'b1);
    $display("a handshake assertion in the bound checker failed");
    stopOnFailure();
  end

  initial begin
    repeat (timeoutCycles) @(posedge s_systemClock);
    $display("TIMEOUT: the tests did not finish within %0d clock cycles", timeoutCycles);
    stopOnFailure();
  end

endmodule

`default_nettype wire

/* verification/ciSubsystem_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ciSubsystemAssertions (
  input logic                              s_systemClock,
  input logic                              s_pllLocked,
  input logic                              ciStart,
  input logic                              ciDone,
  input logic [ciPackage::ciDataWidth-1:0] ciResult
);

  import ciPackage::*;

  logic outstanding;

  // raised by the first assertion that fails
  logic assertionFailed = 1'b0;

  // set by a start and cleared by the done that answers it
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      outstanding <= 1'b0;
    end else if (ciStart) begin
      outstanding <= 1'b1;
    end else if (ciDone) begin
      outstanding <= 1'b0;
    end
  end

  doneSingleCycle: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    ciDone |=> !ciDone
  ) else begin
    assertionFailed = 1'b1;
    $error("ciDone was high for two cycles running");
  end

  resultZeroWhenIdle: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !ciDone |-> (ciResult == ciDataWidth'(0))
  ) else begin
    assertionFailed = 1'b1;
    $error("ciResult is nonzero while ciDone is low");
  end

  noStartWhileOutstanding: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    ciStart |-> !outstanding
  ) else begin
    assertionFailed = 1'b1;
    $error("ciStart came while an instruction was still outstanding");
  end

  doneLowInReset: assert property (
    @(posedge s_systemClock)
    !s_pllLocked |-> !ciDone
  ) else begin
    assertionFailed = 1'b1;
    $error("ciDone is high during reset");
  end

endmodule

bind ciSubsystem ciSubsystemAssertions u_assertions (
  .s_systemClock (s_systemClock),
  .s_pllLocked   (s_pllLocked),
  .ciStart       (ciStart),
  .ciDone        (ciDone),
  .ciResult      (ciResult)
);

`default_nettype wire

/* hdl/ciSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module ciSubsystem (
  input  logic                                s_systemClock,
  input  logic                                s_pllLocked,
  input  logic                                ciStart,
  input  logic [ciPackage::ciNumberWidth-1:0] ciN,
  input  logic [ciPackage::ciDataWidth-1:0]   ciDataA,
  input  logic [ciPackage::ciDataWidth-1:0]   ciDataB,
  output logic                                ciDone,
  output logic [ciPackage::ciDataWidth-1:0]   ciResult
);

  import ciPackage::*;

  ciRequest_t  request;
  ciResponse_t bitResponse;
  ciResponse_t delayResponse;

  // one registered request feeds every execute unit
  ciDecoder u_decoder (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .request       (request)
  );

  ciBitOperations u_bitOperations (
    .request  (request),
    .response (bitResponse)
  );

  ciDelayUnit u_delayUnit (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .request       (request),
    .response      (delayResponse)
  );

  // processor information is answered inside the collector
  ciResultCollector u_resultCollector (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .request       (request),
    .bitResponse   (bitResponse),
    .delayResponse (delayResponse),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

endmodule

`default_nettype wire

/* hdl/ciResultCollector.sv */
`timescale 1ns/1ps
`default_nettype none

module ciResultCollector (
  input  logic                              s_systemClock,
  input  logic                              s_pllLocked,
  input  ciPackage::ciRequest_t             request,
  input  ciPackage::ciResponse_t            bitResponse,
  input  ciPackage::ciResponse_t            delayResponse,
  output logic                              ciDone,
  output logic [ciPackage::ciDataWidth-1:0] ciResult
);

  import ciPackage::*;

  ciResponse_t             infoResponse;
  ciResponse_t             mergedResponse;
  logic [ciCountWidth-1:0] completionCount;

  //////////////////////////////////////////////////////////////////////
  // processor information
  //////////////////////////////////////////////////////////////////////

  // the count read here does not yet include the instruction itself
  always_comb begin
    infoResponse = '0;
    if (request.operation == ciOpProcessorInfo) begin
      infoResponse.done   = 1'b1;
      infoResponse.result = {processorId, completionCount};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // merge and register
  //////////////////////////////////////////////////////////////////////

  // only one unit answers at a time, the others drive zero
  assign mergedResponse = ciResponse_t'(bitResponse | delayResponse | infoResponse);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= mergedResponse.done;
      ciResult <= mergedResponse.done ? mergedResponse.result : '0;
    end
  end

  // counts every done handed to the processor, wrapping at 24 bits
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      completionCount <= '0;
    end else if (mergedResponse.done) begin
      completionCount <= completionCount + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/ciDelayUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module ciDelayUnit (
  input  logic                   s_systemClock,
  input  logic                   s_pllLocked,
  input  ciPackage::ciRequest_t  request,
  output ciPackage::ciResponse_t response
);

  import ciPackage::*;

  logic [ciDataWidth-1:0]      microsecondsLeft;
  logic [ciPrescalerWidth-1:0] prescaler;
  logic                        busy;
  logic                        startDelay;
  logic                        zeroDelay;
  logic                        prescalerWrap;
  logic                        lastTick;

  assign startDelay    = (request.operation == ciOpDelay);
  assign zeroDelay     = startDelay && (request.operandA == '0);
  assign prescalerWrap = busy && (prescaler == '0);

  // the final microsecond ends on the wrap that would take the count to zero
  assign lastTick = prescalerWrap && (microsecondsLeft == ciDataWidth'(1));

  //////////////////////////////////////////////////////////////////////
  // microsecond counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busy             <= 1'b0;
      prescaler        <= '0;
      microsecondsLeft <= '0;
    end else if (startDelay && !zeroDelay) begin
      busy             <= 1'b1;
      prescaler        <= ciPrescalerReload;
      microsecondsLeft <= request.operandA;
    end else if (busy) begin
      if (prescalerWrap) begin
        prescaler        <= ciPrescalerReload;
        microsecondsLeft <= microsecondsLeft - 1'b1;
        if (lastTick) begin
          busy <= 1'b0;
        end
      end else begin
        prescaler <= prescaler - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // a zero count answers in the request cycle without touching the counter
  always_comb begin
    response        = '0;
    response.done   = zeroDelay || lastTick;
    response.result = '0;
  end

endmodule

`default_nettype wire

/* hdl/ciBitOperations.sv */
`timescale 1ns/1ps
`default_nettype none

module ciBitOperations (
  input  ciPackage::ciRequest_t  request,
  output ciPackage::ciResponse_t response
);

  import ciPackage::*;

  logic [ciDataWidth-1:0] swappedBytes;
  logic                   aGreaterThanB;

  // byte 0 goes to the top and byte 3 to the bottom
  assign swappedBytes = {
    request.operandA[7:0],
    request.operandA[15:8],
    request.operandA[23:16],
    request.operandA[31:24]
  };

  // plain relational compare on logic vectors is unsigned
  assign aGreaterThanB = request.operandA > request.operandB;

  always_comb begin
    response = '0;
    case (request.operation)
      ciOpSwapByte: begin
        response.done   = 1'b1;
        response.result = swappedBytes;
      end
      ciOpCompare: begin
        response.done      = 1'b1;
        response.result[0] = aGreaterThanB;
      end
      default: begin
        response = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ciDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ciDecoder (
  input  logic                                s_systemClock,
  input  logic                                s_pllLocked,
  input  logic                                ciStart,
  input  logic [ciPackage::ciNumberWidth-1:0] ciN,
  input  logic [ciPackage::ciDataWidth-1:0]   ciDataA,
  input  logic [ciPackage::ciDataWidth-1:0]   ciDataB,
  output ciPackage::ciRequest_t               request
);

  import ciPackage::*;

  ciOp_t                  decodedOperation;
  ciOp_t                  operationReg;
  logic [ciDataWidth-1:0] operandAReg;
  logic [ciDataWidth-1:0] operandBReg;

  // the number is only looked at while the processor is starting an instruction
  always_comb begin
    decodedOperation = ciOpNone;
    if (ciStart) begin
      case (ciN)
        ciSwapByteId:      decodedOperation = ciOpSwapByte;
        ciProcessorInfoId: decodedOperation = ciOpProcessorInfo;
        ciDelayId:         decodedOperation = ciOpDelay;
        ciCompareId:       decodedOperation = ciOpCompare;
        default:           decodedOperation = ciOpNone;
      endcase
    end
  end

  // operation lasts a single cycle after the start
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      operationReg <= ciOpNone;
    end else begin
      operationReg <= decodedOperation;
    end
  end

  // operands hold their value until the next start
  always_ff @(posedge s_systemClock) begin
    if (ciStart) begin
      operandAReg <= ciDataA;
      operandBReg <= ciDataB;
    end
  end

  assign request = '{
    operation: operationReg,
    operandA:  operandAReg,
    operandB:  operandBReg
  };

endmodule

`default_nettype wire

/* hdl/ciPackage.sv */
`default_nettype none

package ciPackage;

  //////////////////////////////////////////////////////////////////////
  // widths and instruction numbers
  //////////////////////////////////////////////////////////////////////

  localparam int ciDataWidth   = 32;
  localparam int ciNumberWidth = 8;

  // the completion count fills the result below the processor id byte
  localparam int ciCountWidth  = ciDataWidth - ciNumberWidth;

  localparam logic [ciNumberWidth-1:0] ciSwapByteId      = 8'd1;
  localparam logic [ciNumberWidth-1:0] ciProcessorInfoId = 8'd4;
  localparam logic [ciNumberWidth-1:0] ciDelayId         = 8'd6;
  localparam logic [ciNumberWidth-1:0] ciCompareId       = 8'd12;

  localparam logic [ciNumberWidth-1:0] processorId = 8'd1;

  //////////////////////////////////////////////////////////////////////
  // delay timing
  //////////////////////////////////////////////////////////////////////

  // kept small so that simulated delays stay short
  localparam int cyclesPerMicrosecond = 8;
  localparam int ciPrescalerWidth     = $clog2(cyclesPerMicrosecond);

  localparam logic [ciPrescalerWidth-1:0] ciPrescalerReload =
    ciPrescalerWidth'(cyclesPerMicrosecond - 1);

  //////////////////////////////////////////////////////////////////////
  // request and response types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ciOpNone,
    ciOpSwapByte,
    ciOpProcessorInfo,
    ciOpDelay,
    ciOpCompare
  } ciOp_t;

  typedef struct packed {
    ciOp_t                  operation;
    logic [ciDataWidth-1:0] operandA;
    logic [ciDataWidth-1:0] operandB;
  } ciRequest_t;

  // execute units drive all zero when they are not answering
  typedef struct packed {
    logic                   done;
    logic [ciDataWidth-1:0] result;
  } ciResponse_t;

endpackage

`default_nettype wire
